// ==== rtl/ahb_pkg.sv ====
package ahb_pkg;

    // Burst encodings as driven on hburst
    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010,
        INCR4  = 3'b011,
        WRAP8  = 3'b100,
        INCR8  = 3'b101,
        WRAP16 = 3'b110,
        INCR16 = 3'b111
    } burst_e;

    // Transfer types as driven on htrans
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } trans_e;

    // Command captured in the address phase and used in the data phase
    typedef struct packed {
        logic        valid;
        logic        write;
        trans_e      trans;
        burst_e      burst;
        logic [31:0] addr;
    } addr_phase_t;

    // Beat count of a burst, 0 for undefined length
    function automatic logic [3:0] burst_beats(burst_e burst);
        logic [3:0] beats;
        case (burst)
            SINGLE:       beats = 4'd1;
            WRAP4, INCR4: beats = 4'd4;
            WRAP8, INCR8: beats = 4'd8;
            default:      beats = 4'd0; // INCR and the 16-beat codes
        endcase
        return beats;
    endfunction

    function automatic logic burst_is_wrap(burst_e burst);
        logic wrap;
        case (burst)
            WRAP4, WRAP8: wrap = 1'b1;
            default:      wrap = 1'b0; // WRAP16 runs as plain INCR
        endcase
        return wrap;
    endfunction

    function automatic logic trans_is_active(trans_e trans);
        logic active;
        active = (trans == NONSEQ) || (trans == SEQ);
        return active;
    endfunction

endpackage

// ==== rtl/ahb_addr_phase.sv ====
`timescale 1ns/10ps

module ahb_addr_phase (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [31:0]          haddr,
    input  logic                 hwrite,
    input  logic                 hready,
    input  ahb_pkg::trans_e      htrans,
    input  ahb_pkg::burst_e      hburst,
    output ahb_pkg::addr_phase_t dphase
);
    import ahb_pkg::*;

    logic        accept;
    logic        valid_q;
    logic        write_q;
    trans_e      trans_q;
    burst_e      burst_q;
    logic [31:0] addr_q;

    assign accept = hready && trans_is_active(htrans);

    // Valid flag of the data phase
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (hready) begin
            valid_q <= accept;
        end
    end

    // Command fields follow the bus while it is not stalled
    always_ff @(posedge clk) begin
        if (hready) begin
            write_q <= hwrite;
            trans_q <= htrans;
            burst_q <= hburst;
            addr_q  <= haddr;
        end
    end

    always_comb begin
        dphase       = '0;
        dphase.valid = valid_q;
        dphase.write = write_q;
        dphase.trans = trans_q;
        dphase.burst = burst_q;
        dphase.addr  = addr_q;
    end

endmodule

// ==== rtl/burst_addr_gen.sv ====
`timescale 1ns/10ps

module burst_addr_gen (
    input  logic            clk,
    input  logic            rstn,
    input  logic            hready,
    input  logic [31:0]     haddr,
    input  ahb_pkg::trans_e htrans,
    input  ahb_pkg::burst_e hburst,
    output logic [31:0]     beat_addr
);
    import ahb_pkg::*;

    burst_e      burst_q;    // Type of the running burst
    logic [3:0]  beat_cnt;   // Beats issued so far, 0 when idle
    logic [3:0]  beat_lim;
    logic        wrap;
    logic        start;
    logic        seq_acc;
    logic        advance;
    logic [31:0] incr_addr;
    logic [31:0] wrap_mask;
    logic [31:0] next_addr;

    assign start    = hready && (htrans == NONSEQ);
    assign seq_acc  = hready && (htrans == SEQ);
    assign beat_lim = burst_beats(burst_q);
    assign wrap     = burst_is_wrap(burst_q);

    // A SEQ with no burst running, or past the last fixed beat, holds the address
    assign advance = seq_acc && (beat_cnt != 4'd0) &&
                     ((beat_lim == 4'd0) || (beat_cnt < beat_lim));

    always_comb begin
        incr_addr = beat_addr + 32'd4;
        wrap_mask = {26'd0, beat_lim, 2'b00} - 32'd1; // 16 or 32 byte block
        if (wrap) begin
            // Upper bits stay on the boundary, only the offset carries
            next_addr = (beat_addr & ~wrap_mask) | (incr_addr & wrap_mask);
        end else begin
            next_addr = incr_addr;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_addr <= 32'd0;
            burst_q   <= SINGLE;
            beat_cnt  <= 4'd0;
        end else if (start) begin
            beat_addr <= haddr;                   // First beat takes the bus address
            burst_q   <= hburst;
            beat_cnt  <= 4'd1;
        end else if (advance) begin
            beat_addr <= next_addr;               // haddr of SEQ beats is ignored
            if (beat_cnt != 4'hf) begin
                beat_cnt <= beat_cnt + 4'd1;      // Saturates on long INCR bursts
            end
        end
    end

endmodule

// ==== rtl/wait_state_ctrl.sv ====
`timescale 1ns/10ps

module wait_state_ctrl #(
    parameter int WAIT_STATES = 0
) (
    input  logic clk,
    input  logic rstn,
    input  logic dphase_valid,
    output logic hreadyout
);

    localparam int CW = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [CW-1:0] wait_cnt;   // Wait cycles spent in the current data phase
    logic          last_cycle;

    assign last_cycle = (wait_cnt == CW'(WAIT_STATES));

    // Idle bus is always ready
    assign hreadyout = !dphase_valid || last_cycle;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wait_cnt <= '0;
        end else if (dphase_valid && !last_cycle) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;            // Phase done or no phase, next one counts from zero
        end
    end

endmodule

// ==== rtl/mem_array.sv ====
`timescale 1ns/10ps

module mem_array #(
    parameter int MEM_WORDS = 16
) (
    input  logic        clk,
    input  logic        wr_en,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [31:0]   mem [MEM_WORDS];
    logic [31:0]   word_addr;
    logic [AW-1:0] word_idx;

    // Byte address to word index, wrapped to the array depth
    assign word_addr = {2'b00, addr[31:2]};
    assign word_idx  = AW'(word_addr % MEM_WORDS);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[word_idx] <= wdata;
        end
    end

    assign rdata = mem[word_idx]; // Combinational read

endmodule

// ==== rtl/ahb_mem_slave.sv ====
`timescale 1ns/10ps

module ahb_mem_slave #(
    parameter int MEM_WORDS   = 256,
    parameter int WAIT_STATES = 2
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic [31:0]     haddr,
    input  logic            hwrite,
    input  ahb_pkg::trans_e htrans,
    input  ahb_pkg::burst_e hburst,
    input  logic [31:0]     hwdata,
    input  logic            hready,
    output logic            hreadyout,
    output logic [31:0]     hrdata
);
    import ahb_pkg::*;

    addr_phase_t dphase;       // Command of the current data phase
    logic [31:0] beat_addr;
    logic        wr_en;

    // Write lands on the edge that completes the data phase
    assign wr_en = dphase.valid && dphase.write && hreadyout;

    ahb_addr_phase u_addr_phase (
        .clk    (clk),
        .rstn   (rstn),
        .haddr  (haddr),
        .hwrite (hwrite),
        .hready (hready),
        .htrans (htrans),
        .hburst (hburst),
        .dphase (dphase)
    );

    burst_addr_gen u_burst_gen (
        .clk       (clk),
        .rstn      (rstn),
        .hready    (hready),
        .haddr     (haddr),
        .htrans    (htrans),
        .hburst    (hburst),
        .beat_addr (beat_addr)
    );

    wait_state_ctrl #(
        .WAIT_STATES (WAIT_STATES)
    ) u_wait (
        .clk          (clk),
        .rstn         (rstn),
        .dphase_valid (dphase.valid),
        .hreadyout    (hreadyout)
    );

    mem_array #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clk   (clk),
        .wr_en (wr_en),
        .addr  (beat_addr),
        .wdata (hwdata),
        .rdata (hrdata)
    );

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset is released on a rising edge, like any other driven input
    initial begin
        rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

// ==== dv/tb_ahb_mem_slave.sv ====
`timescale 1ns/10ps

module tb_ahb_mem_slave;
    import ahb_pkg::*;

    localparam int MEM_WORDS     = 256;
    localparam int WAIT_STATES   = 2;
    localparam int IW            = $clog2(MEM_WORDS);
    localparam int READY_TIMEOUT = 20;   // Cycles allowed for one data phase
    localparam int RST_TIMEOUT   = 20;

    // One address phase as the master model drives it
    typedef struct packed {
        trans_e      trans;
        logic        write;
        burst_e      burst;
        logic [31:0] addr;
        logic [31:0] wdata;
    } cmd_t;

    logic        clk;
    logic        rstn;
    logic [31:0] haddr;
    logic        hwrite;
    trans_e      htrans;
    burst_e      hburst;
    logic [31:0] hwdata;
    logic        hready;
    logic        hreadyout;
    logic [31:0] hrdata;

    integer      seed;
    cmd_t        cmd_q[$];

    logic           m_valid;     // Reference data phase pending
    logic           m_write;
    burst_e         m_burst;
    logic [31:0]    m_addr;      // Address of the reference data phase
    int             m_wait;
    int             reads_checked;
    logic [31:0]    ref_mem [MEM_WORDS];
    logic [MEM_WORDS-1:0] ref_written;
    logic [IW-1:0]  exp_idx;
    logic [31:0]    exp_rdata;
    logic           exp_ready;
    logic           read_done;

    function automatic logic [IW-1:0] word_index(logic [31:0] addr);
        logic [31:0] word;
        word = addr >> 2;
        return IW'(word % MEM_WORDS);
    endfunction

    // Next beat of a burst, wrapping inside the 16 or 32 byte block
    function automatic logic [31:0] next_beat_addr(logic [31:0] addr, burst_e burst);
        logic [31:0] nxt;
        case (burst)
            WRAP4:   nxt = {addr[31:4], addr[3:0] + 4'd4};
            WRAP8:   nxt = {addr[31:5], addr[4:0] + 5'd4};
            default: nxt = addr + 32'd4;
        endcase
        return nxt;
    endfunction

    function automatic cmd_t idle_cmd(logic write, logic [31:0] addr, logic [31:0] wdata);
        cmd_t c;
        c.trans = IDLE;
        c.write = write;
        c.burst = SINGLE;
        c.addr  = addr;
        c.wdata = wdata;
        return c;
    endfunction

    assign hready    = hreadyout; // Only slave on the bus
    assign exp_idx   = word_index(m_addr);
    assign exp_rdata = ref_mem[exp_idx];
    assign exp_ready = !m_valid || (m_wait == WAIT_STATES);
    assign read_done = m_valid && !m_write && hreadyout;

    tb_clk_gen u_clk_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    ahb_mem_slave #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) u_dut (
        .clk       (clk),
        .rstn      (rstn),
        .haddr     (haddr),
        .hwrite    (hwrite),
        .htrans    (htrans),
        .hburst    (hburst),
        .hwdata    (hwdata),
        .hready    (hready),
        .hreadyout (hreadyout),
        .hrdata    (hrdata)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            m_valid       <= 1'b0;
            m_write       <= 1'b0;
            m_burst       <= SINGLE;
            m_addr        <= 32'd0;
            m_wait        <= 0;
            reads_checked <= 0;
            ref_written   <= '0;
        end else begin
            if (m_valid && hready && m_write) begin
                ref_written[exp_idx] <= 1'b1;
            end
            if (read_done) begin
                reads_checked <= reads_checked + 1;
            end
            if (m_valid && (m_wait != WAIT_STATES)) begin
                m_wait <= m_wait + 1;
            end else begin
                m_wait <= 0;
            end
            if (hready) begin
                m_valid <= (htrans == NONSEQ) || (htrans == SEQ);
                m_write <= hwrite;
                if (htrans == NONSEQ) begin
                    m_addr  <= haddr;
                    m_burst <= hburst;
                end else if (htrans == SEQ) begin
                    m_addr <= next_beat_addr(m_addr, m_burst); // Bus address not used
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rstn && m_valid && hready && m_write) begin
            ref_mem[exp_idx] <= hwdata;
        end
    end

    ready_check: assert property (@(posedge clk) disable iff (!rstn)
        hreadyout == exp_ready)
        else begin
            $display("ERR hreadyout: expected %h, got %h",
                     $sampled(exp_ready), $sampled(hreadyout));
            stop_with_fail();
        end

    read_src_check: assert property (@(posedge clk) disable iff (!rstn)
        read_done |-> ref_written[exp_idx])
        else begin
            $display("Read at address %h hit a word that was never written",
                     $sampled(m_addr));
            stop_with_fail();
        end

    rdata_check: assert property (@(posedge clk) disable iff (!rstn)
        read_done |-> (hrdata == exp_rdata))
        else begin
            $display("ERR hrdata at %h: expected %h, got %h", $sampled(m_addr),
                     $sampled(exp_rdata), $sampled(hrdata));
            stop_with_fail();
        end

    task automatic stop_with_fail();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic add_burst(input logic write, input burst_e burst, input logic [31:0] start,
                             input int beats, input logic busy_after_first);
        cmd_t c;
        int   i;
        for (i = 0; i < beats; i++) begin
            if (i == 0) begin
                c.trans = NONSEQ;
                c.addr  = start;
            end else begin
                c.trans = SEQ;
                c.addr  = $random(seed); // Slave must ignore SEQ addresses
            end
            c.write = write;
            c.burst = burst;
            c.wdata = $random(seed);
            cmd_q.push_back(c);
            if (busy_after_first && (i == 0)) begin
                c.trans = BUSY;
                c.addr  = $random(seed);
                c.wdata = $random(seed);
                cmd_q.push_back(c);
            end
        end
    endtask

    task automatic add_idle(input int cycles, input logic [31:0] addr);
        int i;
        for (i = 0; i < cycles; i++) begin
            cmd_q.push_back(idle_cmd(1'b1, addr, $random(seed)));
        end
    endtask

    task automatic drive_cmd(input cmd_t c);
        htrans <= c.trans;
        hwrite <= c.write;
        hburst <= c.burst;
        haddr  <= c.addr;
    endtask

    task automatic wait_ready(input string what);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!hreadyout && (cycles < READY_TIMEOUT)) begin
            @(posedge clk);
            cycles++;
        end
        if (!hreadyout) begin
            $display("Timeout: hreadyout stayed low too long during %s", what);
            stop_with_fail();
        end
    endtask

    // Address of entry i is accepted on the edge that ends the data phase of entry i-1
    task automatic run_cmds(input string what);
        int i;
        drive_cmd(cmd_q[0]);
        for (i = 0; i < cmd_q.size(); i++) begin
            wait_ready(what);
            hwdata <= cmd_q[i].wdata;
            if (i + 1 < cmd_q.size()) begin
                drive_cmd(cmd_q[i + 1]);
            end else begin
                drive_cmd(idle_cmd(1'b0, 32'd0, 32'd0));
            end
        end
        wait_ready(what); // Last data phase
        cmd_q.delete();
    endtask

    initial begin
        int cycles;
        int beats;
        int idx;
        seed   = 32'hb678_d008;
        haddr  = 32'd0;
        hwrite = 1'b0;
        htrans = IDLE;
        hburst = SINGLE;
        hwdata = 32'd0;

        cycles = 0;
        while ((rstn !== 1'b1) && (cycles < RST_TIMEOUT)) begin
            @(posedge clk);
            cycles++;
        end
        if (rstn !== 1'b1) begin
            $display("Timeout: reset was never released");
            stop_with_fail();
        end

        add_idle(3, 32'h0000_0010);
        run_cmds("idle bus after reset");

        add_burst(1'b1, SINGLE, 32'h0000_0010, 1, 1'b0);
        add_burst(1'b0, SINGLE, 32'h0000_0010, 1, 1'b0);
        run_cmds("single write and read");

        add_burst(1'b1, INCR4, 32'h0000_0040, 4, 1'b0);
        for (idx = 0; idx < 4; idx++) begin
            add_burst(1'b0, SINGLE, 32'h0000_0040 + 32'(idx * 4), 1, 1'b0);
        end
        run_cmds("incr4 burst");

        // Both wrapping bursts start mid-block
        add_burst(1'b1, WRAP4, 32'h0000_0088, 4, 1'b0);
        add_burst(1'b1, WRAP8, 32'h0000_00b4, 8, 1'b0);
        add_burst(1'b0, WRAP4, 32'h0000_0084, 4, 1'b0);
        add_burst(1'b0, WRAP8, 32'h0000_00a8, 8, 1'b0);
        run_cmds("wrap bursts");

        add_idle(2, 32'h0000_0010);
        add_burst(1'b1, INCR8, 32'h0000_0180, 8, 1'b1);
        add_idle(2, 32'h0000_0044);
        add_burst(1'b1, WRAP4, 32'h0000_008c, 4, 1'b1);
        add_idle(1, 32'h0000_0180);
        run_cmds("idle and busy cycles");

        beats = 2 + int'($unsigned($random(seed)) % 32'd5);
        add_burst(1'b1, INCR, 32'h0000_0200, beats, 1'b0);
        add_burst(1'b0, INCR, 32'h0000_0200, beats, 1'b0);
        run_cmds("undefined-length incr");

        // Every word written so far is read back once more
        for (idx = 0; idx < MEM_WORDS; idx++) begin
            if (ref_written[idx]) begin
                add_burst(1'b0, SINGLE, 32'(idx) << 2, 1, 1'b0);
            end
        end
        run_cmds("read-back sweep");

        if (reads_checked == 0) begin
            $display("No read data phase was ever checked");
            stop_with_fail();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// ==== files.f ====
rtl/ahb_pkg.sv
rtl/ahb_addr_phase.sv
rtl/burst_addr_gen.sv
rtl/wait_state_ctrl.sv
rtl/mem_array.sv
rtl/ahb_mem_slave.sv
dv/tb_clk_gen.sv
dv/tb_ahb_mem_slave.sv

// ==== run.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_ahb_mem_slave

rm -f "$LOG"
verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f files.f > "$LOG" 2>&1 \
    && ./obj_dir/V"$TOP" >> "$LOG" 2>&1 \
    || echo "Build or simulation returned an error" >> "$LOG"

cat "$LOG"
grep -qx "Finished with no errors" "$LOG" && echo "PASS" || { echo "FAIL"; exit 1; }
